//--- Makefile
TOP = cpu_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only -Wall -f files.f --top-module cpu_top
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
+incdir+include
+incdir+sim
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/control_unit.sv
logic/regfile.sv
logic/alu.sv
logic/io_ports.sv
logic/cpu_top.sv
sim/cpu_tb.sv

//--- include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and instruction width
`define CPU_DATA_W 8

// Register number width, four registers
`define CPU_REG_AW 2

// Opcode field in the top bits of an instruction
`define CPU_OPC_W 4

// Instruction memory size in bytes
`define CPU_IMEM_DEPTH 256

`endif

//--- logic/alu.sv
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  wire               clk,
    input  wire               rst_n,
    input  cpu_pkg::data_t    a,
    input  cpu_pkg::data_t    b,
    input  cpu_pkg::alu_op_t  op,
    input  wire               flag_we_zn,
    input  wire               flag_we_cv,
    output cpu_pkg::data_t    result,
    output cpu_pkg::flags_t   flags
);

    cpu_pkg::data_t         add_b;
    logic                   add_cin;
    logic [`CPU_DATA_W:0]   sum;
    logic                   sum_ovf;

    // One adder serves ADD, SUB and INC
    always_comb begin
        add_b   = b;
        add_cin = 1'b0;
        if (op == cpu_pkg::ALU_SUB) begin
            add_b   = ~b;
            add_cin = 1'b1;
        end else if (op == cpu_pkg::ALU_INC) begin
            add_b = cpu_pkg::data_t'(1);
        end
    end

    assign sum = {1'b0, a} + {1'b0, add_b} + {{`CPU_DATA_W{1'b0}}, add_cin};

    // Signed overflow, same-sign operands giving a result of the other sign
    assign sum_ovf = (a[`CPU_DATA_W-1] == add_b[`CPU_DATA_W-1])
                  && (sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_SUB,
            cpu_pkg::ALU_INC: result = sum[`CPU_DATA_W-1:0];
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_NOT: result = ~a;
            default:          result = b;
        endcase
    end

    // Condition code register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            if (flag_we_zn) begin
                flags.z <= (result == '0);
                flags.n <= result[`CPU_DATA_W-1];
            end
            if (flag_we_cv) begin
                // Carry set on SUB means no borrow
                flags.c <= sum[`CPU_DATA_W];
                flags.v <= sum_ovf;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`default_nettype none

`include "cpu_cfg.svh"

module control_unit (
    input  cpu_pkg::data_t     instr,
    input  cpu_pkg::flags_t    flags,
    input  wire                halted,
    output cpu_pkg::reg_addr_t ra,
    output cpu_pkg::reg_addr_t rb,
    output logic               reg_we,
    output cpu_pkg::wd_sel_t   wd_sel,
    output cpu_pkg::alu_op_t   alu_op,
    output logic               flag_we_zn,
    output logic               flag_we_cv,
    output logic               out_ld,
    output logic               halt_set,
    output logic               pc_load,
    output logic               skip_imm
);

    cpu_pkg::opcode_t opcode;

    assign opcode = cpu_pkg::opcode_t'(instr[`CPU_DATA_W-1 -: `CPU_OPC_W]);
    assign ra     = instr[2*`CPU_REG_AW-1 -: `CPU_REG_AW];
    assign rb     = instr[`CPU_REG_AW-1:0];

    always_comb begin
        reg_we     = 1'b0;
        wd_sel     = cpu_pkg::WD_ALU;
        alu_op     = cpu_pkg::ALU_PASS_B;
        flag_we_zn = 1'b0;
        flag_we_cv = 1'b0;
        out_ld     = 1'b0;
        halt_set   = 1'b0;
        pc_load    = 1'b0;
        skip_imm   = 1'b0;

        if (!halted) begin
            case (opcode)
                cpu_pkg::OP_MOV: begin
                    reg_we = 1'b1;
                end
                cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_INC: begin
                    reg_we     = 1'b1;
                    flag_we_zn = 1'b1;
                    flag_we_cv = 1'b1;
                    case (opcode)
                        cpu_pkg::OP_ADD: alu_op = cpu_pkg::ALU_ADD;
                        cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
                        default:         alu_op = cpu_pkg::ALU_INC;
                    endcase
                end
                cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_NOT: begin
                    reg_we     = 1'b1;
                    flag_we_zn = 1'b1;
                    case (opcode)
                        cpu_pkg::OP_AND: alu_op = cpu_pkg::ALU_AND;
                        cpu_pkg::OP_OR:  alu_op = cpu_pkg::ALU_OR;
                        default:         alu_op = cpu_pkg::ALU_NOT;
                    endcase
                end
                cpu_pkg::OP_LDI: begin
                    reg_we   = 1'b1;
                    wd_sel   = cpu_pkg::WD_IMM;
                    skip_imm = 1'b1;
                end
                cpu_pkg::OP_IN: begin
                    reg_we = 1'b1;
                    wd_sel = cpu_pkg::WD_IN;
                end
                cpu_pkg::OP_OUT: out_ld   = 1'b1;
                cpu_pkg::OP_JMP: pc_load  = 1'b1;
                // Conditions come from the stored flags
                cpu_pkg::OP_JZ:  pc_load  = flags.z;
                cpu_pkg::OP_JC:  pc_load  = flags.c;
                cpu_pkg::OP_HLT: halt_set = 1'b1;
                // NOP and the unused code 15
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    // Bit 0 is zero, bit 3 is overflow
    typedef struct packed {
        logic v;
        logic c;
        logic n;
        logic z;
    } flags_t;

    typedef enum logic [`CPU_OPC_W-1:0] {
        OP_NOP = 4'd0,
        OP_MOV = 4'd1,
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_NOT = 4'd6,
        OP_INC = 4'd7,
        OP_LDI = 4'd8,
        OP_IN  = 4'd9,
        OP_OUT = 4'd10,
        OP_JMP = 4'd11,
        OP_JZ  = 4'd12,
        OP_JC  = 4'd13,
        OP_HLT = 4'd14
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_NOT    = 3'd5,
        ALU_INC    = 3'd6
    } alu_op_t;

    // Register write data source
    typedef enum logic [1:0] {
        WD_ALU = 2'd0,
        WD_IMM = 2'd1,
        WD_IN  = 2'd2
    } wd_sel_t;

endpackage

`default_nettype wire

//--- logic/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              prog_we,
    input  cpu_pkg::data_t   prog_addr,
    input  cpu_pkg::data_t   prog_data,
    input  cpu_pkg::data_t   in_port,
    output cpu_pkg::data_t   out_port,
    output logic             out_valid,
    output logic             hlt
);

    cpu_pkg::data_t     instr;
    cpu_pkg::data_t     imm;
    cpu_pkg::reg_addr_t ra;
    cpu_pkg::reg_addr_t rb;
    logic               reg_we;
    cpu_pkg::wd_sel_t   wd_sel;
    cpu_pkg::alu_op_t   alu_op;
    logic               flag_we_zn;
    logic               flag_we_cv;
    logic               out_ld;
    logic               halt_set;
    logic               pc_load;
    logic               skip_imm;
    cpu_pkg::data_t     rd_a;
    cpu_pkg::data_t     rd_b;
    cpu_pkg::data_t     alu_result;
    cpu_pkg::flags_t    flags;
    cpu_pkg::data_t     wd;

    fetch_unit fetch_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc_load   (pc_load),
        .pc_target (rd_b),
        .skip_imm  (skip_imm),
        .halt      (hlt),
        .instr     (instr),
        .imm       (imm)
    );

    control_unit control_unit_inst (
        .instr      (instr),
        .flags      (flags),
        .halted     (hlt),
        .ra         (ra),
        .rb         (rb),
        .reg_we     (reg_we),
        .wd_sel     (wd_sel),
        .alu_op     (alu_op),
        .flag_we_zn (flag_we_zn),
        .flag_we_cv (flag_we_cv),
        .out_ld     (out_ld),
        .halt_set   (halt_set),
        .pc_load    (pc_load),
        .skip_imm   (skip_imm)
    );

    regfile regfile_inst (
        .clk  (clk),
        .we   (reg_we),
        .ra   (ra),
        .rb   (rb),
        .wd   (wd),
        .rd_a (rd_a),
        .rd_b (rd_b)
    );

    alu alu_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .a          (rd_a),
        .b          (rd_b),
        .op         (alu_op),
        .flag_we_zn (flag_we_zn),
        .flag_we_cv (flag_we_cv),
        .result     (alu_result),
        .flags      (flags)
    );

    // Writeback source
    always_comb begin
        case (wd_sel)
            cpu_pkg::WD_IMM: wd = imm;
            cpu_pkg::WD_IN:  wd = in_port;
            default:         wd = alu_result;
        endcase
    end

    io_ports io_ports_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_ld    (out_ld),
        .out_data  (rd_b),
        .halt_set  (halt_set),
        .out_port  (out_port),
        .out_valid (out_valid),
        .hlt       (hlt)
    );

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`default_nettype none

`include "cpu_cfg.svh"

module fetch_unit (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              prog_we,
    input  cpu_pkg::data_t   prog_addr,
    input  cpu_pkg::data_t   prog_data,
    input  wire              pc_load,
    input  cpu_pkg::data_t   pc_target,
    input  wire              skip_imm,
    input  wire              halt,
    output cpu_pkg::data_t   instr,
    output cpu_pkg::data_t   imm
);

    // Opcode NOP with zero operand fields
    localparam cpu_pkg::data_t NOP_INSTR =
        {cpu_pkg::OP_NOP, {(`CPU_DATA_W - `CPU_OPC_W){1'b0}}};

    cpu_pkg::data_t imem [`CPU_IMEM_DEPTH];
    cpu_pkg::data_t pc;
    cpu_pkg::data_t ir;
    cpu_pkg::data_t pc_next;
    cpu_pkg::data_t ir_next;

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // Byte after the instruction being executed
    assign imm   = imem[pc];
    assign instr = ir;

    always_comb begin
        pc_next = pc + cpu_pkg::data_t'(1);
        ir_next = imem[pc];
        if (pc_load) begin
            // Taken jump, the byte fetched in this cycle is discarded
            pc_next = pc_target;
            ir_next = NOP_INSTR;
        end else if (skip_imm) begin
            // Immediate byte consumed by LDI
            ir_next = NOP_INSTR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
            ir <= NOP_INSTR;
        end else if (!halt) begin
            pc <= pc_next;
            ir <= ir_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/io_ports.sv
`default_nettype none

module io_ports (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              out_ld,
    input  cpu_pkg::data_t   out_data,
    input  wire              halt_set,
    output cpu_pkg::data_t   out_port,
    output logic             out_valid,
    output logic             hlt
);

    // Output data holds until the next OUT
    always_ff @(posedge clk) begin
        if (out_ld) begin
            out_port <= out_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            hlt       <= 1'b0;
        end else begin
            // One-cycle strobe per OUT
            out_valid <= out_ld;
            // Sticky until reset
            hlt       <= hlt | halt_set;
        end
    end

endmodule

`default_nettype wire

//--- logic/regfile.sv
`default_nettype none

`include "cpu_cfg.svh"

module regfile (
    input  wire                clk,
    input  wire                we,
    input  cpu_pkg::reg_addr_t ra,
    input  cpu_pkg::reg_addr_t rb,
    input  cpu_pkg::data_t     wd,
    output cpu_pkg::data_t     rd_a,
    output cpu_pkg::data_t     rd_b
);

    cpu_pkg::data_t regs [2**`CPU_REG_AW];

    // Destination is always the ra field
    always_ff @(posedge clk) begin
        if (we) begin
            regs[ra] <= wd;
        end
    end

    assign rd_a = regs[ra];
    assign rd_b = regs[rb];

endmodule

`default_nettype wire

//--- sim/cpu_tests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

task automatic test_arith_ops();
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    next_random(a);
    next_random(b);
    prog_q.delete();
    exp_q.delete();
    emit_ldi(2'd0, a);
    emit_ldi(2'd1, b);
    // r2 is rebuilt from r0 before each operation
    emit(cpu_pkg::OP_MOV, 2'd2, 2'd0);
    emit(cpu_pkg::OP_ADD, 2'd2, 2'd1);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_MOV, 2'd2, 2'd0);
    emit(cpu_pkg::OP_SUB, 2'd2, 2'd1);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_MOV, 2'd2, 2'd0);
    emit(cpu_pkg::OP_INC, 2'd2, 2'd0);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_MOV, 2'd3, 2'd1);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd3);
    emit(cpu_pkg::OP_HLT, 2'd0, 2'd0);
    exp_q.push_back(a + b);
    exp_q.push_back(a - b);
    exp_q.push_back(a + 8'd1);
    exp_q.push_back(b);
    run_program(2);
    check_outputs();
endtask

task automatic test_logic_ops();
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    next_random(a);
    next_random(b);
    prog_q.delete();
    exp_q.delete();
    emit_ldi(2'd0, a);
    emit_ldi(2'd1, b);
    emit(cpu_pkg::OP_MOV, 2'd2, 2'd0);
    emit(cpu_pkg::OP_AND, 2'd2, 2'd1);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_MOV, 2'd2, 2'd0);
    emit(cpu_pkg::OP_OR, 2'd2, 2'd1);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_MOV, 2'd2, 2'd0);
    emit(cpu_pkg::OP_NOT, 2'd2, 2'd0);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_HLT, 2'd0, 2'd0);
    exp_q.push_back(a & b);
    exp_q.push_back(a | b);
    exp_q.push_back(~a);
    run_program(2);
    check_outputs();
endtask

// ALU op on x and y into r0, then a conditional jump over OUT r0
task automatic jump_case(cpu_pkg::opcode_t alu_opc, cpu_pkg::opcode_t jump_opc,
                         cpu_pkg::data_t x, cpu_pkg::data_t y);
    logic [8:0] wide;
    logic       taken;
    emit_ldi(2'd0, x);
    emit_ldi(2'd1, y);
    // Target is the byte right after the OUT
    emit_ldi(2'd3, cpu_pkg::data_t'(prog_q.size() + 5));
    emit(alu_opc, 2'd0, 2'd1);
    emit(jump_opc, 2'd0, 2'd3);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd0);
    if (alu_opc == cpu_pkg::OP_SUB) begin
        // Carry after SUB means nothing was borrowed
        wide[8]   = (x >= y);
        wide[7:0] = x - y;
    end else begin
        wide = {1'b0, x} + {1'b0, y};
    end
    if (jump_opc == cpu_pkg::OP_JZ) begin
        taken = (wide[7:0] == 8'h00);
    end else begin
        taken = wide[8];
    end
    if (!taken) begin
        exp_q.push_back(wide[7:0]);
    end
endtask

task automatic test_branches();
    cpu_pkg::data_t x;
    cpu_pkg::data_t y;
    prog_q.delete();
    exp_q.delete();
    next_random(x);
    jump_case(cpu_pkg::OP_SUB, cpu_pkg::OP_JZ, x, x);
    next_random(x);
    next_random(y);
    jump_case(cpu_pkg::OP_ADD, cpu_pkg::OP_JC, x | 8'h80, y | 8'h80);
    next_random(x);
    next_random(y);
    jump_case(cpu_pkg::OP_ADD, cpu_pkg::OP_JZ, x & 8'h7f, (y & 8'h3f) | 8'h01);
    next_random(x);
    next_random(y);
    // Small minus large borrows, so no carry
    jump_case(cpu_pkg::OP_SUB, cpu_pkg::OP_JC, x & 8'h3f, y | 8'h80);
    emit_ldi(2'd3, cpu_pkg::data_t'(prog_q.size() + 4));
    emit(cpu_pkg::OP_JMP, 2'd0, 2'd3);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd0);
    emit(cpu_pkg::OP_HLT, 2'd0, 2'd0);
    run_program(2);
    check_outputs();
endtask

task automatic test_input_port();
    cpu_pkg::data_t v;
    next_random(v);
    @(posedge clk);
    in_port <= v;
    prog_q.delete();
    exp_q.delete();
    emit(cpu_pkg::OP_IN, 2'd2, 2'd0);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd2);
    emit(cpu_pkg::OP_HLT, 2'd0, 2'd0);
    exp_q.push_back(v);
    run_program(2);
    check_outputs();
endtask

task automatic test_halt();
    cpu_pkg::data_t v;
    next_random(v);
    prog_q.delete();
    exp_q.delete();
    emit_ldi(2'd1, v);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd1);
    emit(cpu_pkg::OP_HLT, 2'd0, 2'd0);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd1);
    emit(cpu_pkg::OP_OUT, 2'd0, 2'd1);
    emit(cpu_pkg::OP_HLT, 2'd0, 2'd0);
    exp_q.push_back(v);
    // Nothing may come out in the 50 cycles after halt
    run_program(50);
    check_outputs();
endtask

`endif

//--- sim/cpu_tb.sv
`default_nettype none

module cpu_tb;

    localparam logic [31:0] SEED = 32'h9744_d9f6;
    localparam int RESET_CYCLES = 16;
    // Five programs, each well under 600 cycles with load and halt wait
    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 600;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * CYCLES_PER_TEST;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           prog_we;
    cpu_pkg::data_t prog_addr;
    cpu_pkg::data_t prog_data;
    cpu_pkg::data_t in_port;
    cpu_pkg::data_t out_port;
    logic           out_valid;
    logic           hlt;

    cpu_pkg::data_t prog_q[$];
    cpu_pkg::data_t exp_q[$];
    cpu_pkg::data_t out_q[$];
    logic [31:0]    rng_state;
    int             cycle_count = 0;

    always #4 clk = ~clk;

    cpu_top cpu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .in_port   (in_port),
        .out_port  (out_port),
        .out_valid (out_valid),
        .hlt       (hlt)
    );

    // Output strobes, sampled mid-cycle
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            out_q.push_back(out_port);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_out(string name, cpu_pkg::data_t got, cpu_pkg::data_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_hlt(logic got, logic exp);
        if (got !== exp) begin
            $display("error: hlt got 0x%h expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output cpu_pkg::data_t v);
        rng_state = xorshift32(rng_state);
        v = rng_state[7:0];
    endtask

    function automatic cpu_pkg::data_t encode(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t ra,
                                              cpu_pkg::reg_addr_t rb);
        return {op, ra, rb};
    endfunction

    task automatic emit(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t ra, cpu_pkg::reg_addr_t rb);
        prog_q.push_back(encode(op, ra, rb));
    endtask

    // LDI opcode byte followed by the immediate byte
    task automatic emit_ldi(cpu_pkg::reg_addr_t ra, cpu_pkg::data_t value);
        emit(cpu_pkg::OP_LDI, ra, 2'd0);
        prog_q.push_back(value);
    endtask

    // Loads prog_q under reset, runs to halt, then waits settle cycles
    task automatic run_program(int settle);
        int hold;
        int i;
        out_q.delete();
        hold = (prog_q.size() > RESET_CYCLES) ? prog_q.size() : RESET_CYCLES;
        for (i = 0; i < hold; i++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            prog_we <= (i < prog_q.size());
            prog_addr <= cpu_pkg::data_t'(i);
            prog_data <= (i < prog_q.size()) ? prog_q[i] : 8'h00;
        end
        @(posedge clk);
        prog_we <= 1'b0;
        rst_n <= 1'b1;
        @(negedge clk);
        check_hlt(hlt, 1'b0);
        while (hlt !== 1'b1) begin
            @(negedge clk);
        end
        repeat (settle) @(negedge clk);
        check_hlt(hlt, 1'b1);
    endtask

    task automatic check_outputs();
        int i;
        if (out_q.size() != exp_q.size()) begin
            $display("wrong number of output strobes: got %0d, expected %0d",
                     out_q.size(), exp_q.size());
            abort_run();
        end else begin
            for (i = 0; i < exp_q.size(); i++) begin
                check_out($sformatf("out_port[%0d]", i), out_q[i], exp_q[i]);
            end
        end
    endtask

    `include "cpu_tests.svh"

    initial begin
        rst_n = 1'b0;
        prog_we = 1'b0;
        prog_addr = 8'h00;
        prog_data = 8'h00;
        in_port = 8'h00;
        rng_state = SEED;
        test_arith_ops();
        test_logic_ops();
        test_branches();
        test_input_port();
        test_halt();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
